//--- sim.f
common/gate_num_pkg.sv
common/gate_lut_pkg.sv
common/gate_term_if.sv
rtl/gate_product_stage.sv
rtl/gate_sum_stage.sv
logistic/gate_logistic_stage.sv
rtl/output_gate_top.sv
dv/output_gate_tb.sv

//--- Bender.yml
package:
  name: output_gate

sources:
  # Packages and interface
  - common/gate_num_pkg.sv
  - common/gate_lut_pkg.sv
  - common/gate_term_if.sv
  # Pipeline stages
  - rtl/gate_product_stage.sv
  - rtl/gate_sum_stage.sv
  - logistic/gate_logistic_stage.sv
  # Top level
  - rtl/output_gate_top.sv
  # Testbench
  - target: test
    files:
      - dv/output_gate_tb.sv

//--- dv/output_gate_tb.sv
// Output gate testbench
// Directed and LFSR stimulus, reference model and in-order comparison
`timescale 1ns/100ps
`default_nettype none

module output_gate_tb;

  // Clock period in ns
  localparam int clk_ns  = 4;
  // Vectors in the last-flag test, up to 8 elements each
  localparam int n_vec   = 12;
  localparam int n_elems = 5 + 200 + n_vec * 8;
  localparam int wd_ns   = (n_elems + 20) * clk_ns * 2;

  logic               CLK;
  logic               RST;
  logic               in_valid;
  logic               in_last;
  logic signed [15:0] w;
  logic signed [15:0] x;
  logic signed [15:0] k;
  logic signed [15:0] r;
  logic signed [15:0] u;
  logic signed [15:0] h;
  logic signed [15:0] b;
  logic               out_valid;
  logic               out_last;
  logic signed [15:0] o;

  // Logistic base points, sigmoid(i) * 2048
  int          base_tab [0:8];
  logic [31:0] lfsr_state;
  // Rising edges seen so far
  int          cyc = 0;

  // Expected stream, oldest element first
  int          exp_o_q    [$];
  logic        exp_last_q [$];
  int          due_q      [$];
  string       name_q     [$];

  int          exp_o;
  logic        exp_last;
  int          due;
  string       name;

  output_gate_top i_dut (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (in_valid),
    .in_last   (in_last),
    .w         (w),
    .x         (x),
    .k         (k),
    .r         (r),
    .u         (u),
    .h         (h),
    .b         (b),
    .out_valid (out_valid),
    .out_last  (out_last),
    .o         (o)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "Run stopped at %0t", $time);
  endtask

  function automatic void build_table();
    for (int i = 0; i <= 8; i++) begin
      base_tab[i] = $rtoi(2048.0 / (1.0 + $exp(-real'(i))) + 0.5);
    end
  endfunction

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Signed word from n random bits, sign-extended
  function automatic logic signed [15:0] rand_word(input int n);
    logic signed [31:0] t;
    t = rand_bits(n) << (32 - n);
    t = t >>> (32 - n);
    return t[15:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic int ref_gate(input logic signed [15:0] wv, xv, kv, rv, uv, hv, bv);
    longint acc;
    longint pre;
    longint mag;
    int     ip;
    int     fr;
    int     y;
    acc = longint'(wv) * longint'(xv) + longint'(kv) * longint'(rv)
        + longint'(uv) * longint'(hv) + longint'(bv) * 2048;
    // Floor to Q4.11, then clamp to the word range
    pre = acc >>> 11;
    if (pre > 32767) pre = 32767;
    else if (pre < -32768) pre = -32768;
    mag = (pre < 0) ? -pre : pre;
    if (mag > 32767) mag = 32767;
    ip = int'(mag / 2048);
    fr = int'(mag % 2048);
    if (ip >= 8) begin
      y = base_tab[8];
    end else begin
      y = base_tab[ip] + ((base_tab[ip + 1] - base_tab[ip]) * fr) / 2048;
    end
    return (pre < 0) ? 2048 - y : y;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic send(input string tname, input logic signed [15:0] wv, xv, kv, rv, uv, hv,
                      input logic signed [15:0] bv, input logic last_v);
    @(posedge CLK);
    in_valid <= 1'b1;
    in_last  <= last_v;
    w <= wv;
    x <= xv;
    k <= kv;
    r <= rv;
    u <= uv;
    h <= hv;
    b <= bv;
    exp_o_q.push_back(ref_gate(wv, xv, kv, rv, uv, hv, bv));
    exp_last_q.push_back(last_v);
    // Sampled at the falling edge after the third register
    due_q.push_back(cyc + 4);
    name_q.push_back(tname);
  endtask

  // Operands within +-2.0 and bias within +-4.0
  // Sums stay mostly on the interpolated segments
  task automatic send_random(input string tname, input logic last_v);
    logic signed [15:0] rw;
    logic signed [15:0] rx;
    logic signed [15:0] rk;
    logic signed [15:0] rr;
    logic signed [15:0] ru;
    logic signed [15:0] rh;
    logic signed [15:0] rb;
    rw = rand_word(13);
    rx = rand_word(13);
    rk = rand_word(13);
    rr = rand_word(13);
    ru = rand_word(13);
    rh = rand_word(13);
    rb = rand_word(14);
    send(tname, rw, rx, rk, rr, ru, rh, rb, last_v);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge CLK);
      in_valid <= 1'b0;
      in_last  <= 1'b0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Clock, edge count, watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    CLK = 1'b0;
    forever #(clk_ns / 2) CLK = ~CLK;
  end

  always @(posedge CLK) cyc <= cyc + 1;

  initial begin
    #(wd_ns);
    stop_run("Watchdog timeout, the tests did not finish in time");
  end

  //////////////////////////////////////////////////////////////////////
  // Comparator
  //////////////////////////////////////////////////////////////////////

  // Outputs settle after the rising edge, checked at the falling one
  always @(negedge CLK) begin
    if (RST || due_q.size() == 0) begin
      assert (out_valid === 1'b0 && out_last === 1'b0)
        else stop_run("Output strobe while in reset or with no element in flight");
    end else if (out_valid === 1'b1) begin
      exp_o    = exp_o_q.pop_front();
      exp_last = exp_last_q.pop_front();
      due      = due_q.pop_front();
      name     = name_q.pop_front();
      assert (cyc == due) else begin
        $display("CHECK FAILED %s latency: expected cycle %0d, actual cycle %0d", name, due, cyc);
        stop_run("Output strobe at the wrong cycle");
      end
      assert (int'(o) == exp_o) else begin
        $display("CHECK FAILED %s o: expected %0d, actual %0d", name, exp_o, o);
        stop_run("Gate value mismatch");
      end
      assert (out_last === exp_last) else begin
        $display("CHECK FAILED %s out_last: expected %0b, actual %0b", name, exp_last, out_last);
        stop_run("Last flag mismatch");
      end
    end else begin
      assert (due_q[0] > cyc) else stop_run("An expected output did not appear in time");
      assert (out_last === 1'b0) else stop_run("out_last high without out_valid");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    build_table();
    lfsr_state = 32'h2ec57dab;
    RST      = 1'b1;
    in_valid = 1'b0;
    in_last  = 1'b0;
    w = '0;
    x = '0;
    k = '0;
    r = '0;
    u = '0;
    h = '0;
    b = '0;

    // Model against the known points
    assert (ref_gate(0, 0, 0, 0, 0, 0, 0) == 1024) else stop_run("Reference model wrong at 0");
    assert (ref_gate(0, 0, 0, 0, 0, 0, 2048) == 1497) else stop_run("Reference model wrong at 1.0");
    assert (ref_gate(0, 0, 0, 0, 0, 0, -2048) == 551) else stop_run("Reference model wrong at -1.0");

    // Reset, then idle with outputs watched
    repeat (4) @(posedge CLK);
    RST <= 1'b0;
    idle(6);

    // Directed points
    send("zero", 0, 0, 0, 0, 0, 0, 0, 1'b1);
    idle(4);
    send("plus_one", 0, 0, 0, 0, 0, 0, 2048, 1'b1);
    idle(4);
    send("minus_one", 0, 0, 0, 0, 0, 0, -2048, 1'b1);
    idle(4);
    send("sat_high", 32767, 32767, 32767, 32767, 32767, 32767, 32767, 1'b1);
    idle(4);
    send("sat_low", 32767, -32768, 32767, -32768, 32767, -32768, -32768, 1'b1);
    idle(4);

    // Back-to-back random stream
    for (int i = 0; i < 200; i++) begin
      send_random("random_stream", (i % 8) == 7);
    end
    idle(4);

    // Vectors of 1 to 8 elements with gaps
    for (int v = 0; v < n_vec; v++) begin
      int len;
      len = int'(rand_bits(3)) + 1;
      for (int j = 0; j < len; j++) begin
        send_random("vector", j == len - 1);
      end
      idle(int'(rand_bits(2)) + 1);
    end

    // Drain
    idle(8);
    if (due_q.size() != 0) begin
      stop_run("Elements still in flight at the end of the run");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- rtl/output_gate_top.sv
// Output gate top level
// o = sigmoid(w*x + k*r + u*h + b) per element, three-stage stream
// One element per cycle, result three cycles after the strobe
`timescale 1ns/100ps
`default_nettype none

module output_gate_top (
  input  logic                CLK,
  input  logic                RST,

  // Input element
  input  logic                in_valid,
  input  logic                in_last,
  input  gate_num_pkg::word_t w,
  input  gate_num_pkg::word_t x,
  input  gate_num_pkg::word_t k,
  input  gate_num_pkg::word_t r,
  input  gate_num_pkg::word_t u,
  input  gate_num_pkg::word_t h,
  input  gate_num_pkg::word_t b,

  // Gate output, no back-pressure
  output logic                out_valid,
  output logic                out_last,
  output gate_num_pkg::word_t o
);

  ///////////////////////////////////////////////////////////////////////
  // Stage links
  ///////////////////////////////////////////////////////////////////////

  gate_term_if          terms ();

  logic                 pre_valid;
  logic                 pre_last;
  gate_num_pkg::word_t  pre;

  ///////////////////////////////////////////////////////////////////////
  // Pipeline
  ///////////////////////////////////////////////////////////////////////

  // Products
  gate_product_stage i_product (
    .CLK      (CLK),
    .RST      (RST),
    .in_valid (in_valid),
    .in_last  (in_last),
    .w        (w),
    .x        (x),
    .k        (k),
    .r        (r),
    .u        (u),
    .h        (h),
    .b        (b),
    .terms    (terms.src)
  );

  // Biased sum, saturated
  gate_sum_stage i_sum (
    .CLK       (CLK),
    .RST       (RST),
    .terms     (terms.dst),
    .pre_valid (pre_valid),
    .pre_last  (pre_last),
    .pre       (pre)
  );

  // Sigmoid
  gate_logistic_stage i_logistic (
    .CLK       (CLK),
    .RST       (RST),
    .pre_valid (pre_valid),
    .pre_last  (pre_last),
    .pre       (pre),
    .out_valid (out_valid),
    .out_last  (out_last),
    .o         (o)
  );

endmodule

`default_nettype wire

//--- logistic/gate_logistic_stage.sv
// Output gate, stage 3
// Piecewise-linear sigmoid over unit segments on [0, 8],
// mirrored for negative inputs as 1 - sigmoid(|x|)
`timescale 1ns/100ps
`default_nettype none

module gate_logistic_stage (
  input  logic                 CLK,
  input  logic                 RST,

  // Pre-activation from the sum stage
  input  logic                 pre_valid,
  input  logic                 pre_last,
  input  gate_num_pkg::word_t  pre,

  // Gate value in Q4.11 strictly between 0 and 1
  output logic                 out_valid,
  output logic                 out_last,
  output gate_num_pkg::word_t  o
);

  // Segment index width
  localparam int seg_w = $clog2(gate_lut_pkg::seg_n);

  localparam gate_num_pkg::word_t word_max = {1'b0, {(gate_num_pkg::word_w-1){1'b1}}};
  localparam gate_num_pkg::word_t word_min = {1'b1, {(gate_num_pkg::word_w-1){1'b0}}};

  gate_num_pkg::pre_word_u   pre_u;
  gate_num_pkg::pre_word_u   mag_u;
  logic                      neg;
  logic [seg_w-1:0]          seg;
  logic [11:0]               base_lo;
  logic [11:0]               base_hi;
  logic [11:0]               step;
  logic [22:0]               ramp;
  logic [11:0]               y;

  ///////////////////////////////////////////////////////////////////////
  // Magnitude
  ///////////////////////////////////////////////////////////////////////

  always_comb begin
    pre_u.value = pre;
    neg         = pre_u.value < 0;
    // -32768 has no positive twin, folds onto 32767
    if (!neg) begin
      mag_u.value = pre_u.value;
    end else if (pre_u.value == word_min) begin
      mag_u.value = word_max;
    end else begin
      mag_u.value = -pre_u.value;
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Segment interpolation
  ///////////////////////////////////////////////////////////////////////

  always_comb begin
    // Low bits of the integer part pick the segment
    seg     = mag_u.fields.int_part[seg_w-1:0];
    base_lo = gate_lut_pkg::sig_base[seg];
    base_hi = gate_lut_pkg::sig_base[seg + 1];
    step    = base_hi - base_lo;
    // Slope times fractional offset, back to Q.11
    ramp    = step * mag_u.fields.frac;

    // Flat tail past the table
    if (mag_u.fields.int_part >= gate_lut_pkg::seg_n) begin
      y = gate_lut_pkg::sig_base[gate_lut_pkg::seg_n];
    end else begin
      y = base_lo + ramp[gate_num_pkg::frac_w +: 12];
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Output register
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
      o         <= '0;
    end else begin
      out_valid <= pre_valid;
      out_last  <= pre_valid & pre_last;
      if (pre_valid) begin
        // Odd symmetry about 0.5
        o <= neg ? gate_num_pkg::word_t'(gate_num_pkg::one_q - y)
                 : gate_num_pkg::word_t'(y);
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/gate_sum_stage.sv
// Output gate, stage 2
// Biased sum of the three products, floor rescale to Q4.11
// and saturation to the word range
`timescale 1ns/100ps
`default_nettype none

module gate_sum_stage (
  input  logic                 CLK,
  input  logic                 RST,

  // From the product stage
  gate_term_if.dst             terms,

  // Pre-activation to the logistic stage
  output logic                 pre_valid,
  output logic                 pre_last,
  output gate_num_pkg::word_t  pre
);

  // Two guard bits over the product width
  localparam int acc_w = gate_num_pkg::prod_w + 2;

  typedef logic signed [acc_w-1:0] acc_t;

  // Word range in accumulator width
  localparam acc_t word_max = (acc_t'(1) <<< (gate_num_pkg::word_w - 1)) - acc_t'(1);
  localparam acc_t word_min = -(acc_t'(1) <<< (gate_num_pkg::word_w - 1));

  acc_t                bias_al;
  acc_t                acc;
  acc_t                scaled;
  gate_num_pkg::word_t sat;

  ///////////////////////////////////////////////////////////////////////
  // Sum and rescale
  ///////////////////////////////////////////////////////////////////////

  always_comb begin
    // Bias up to Q8.22
    bias_al = acc_t'(terms.bias) <<< gate_num_pkg::frac_w;
    acc     = acc_t'(terms.p_wx) + acc_t'(terms.p_kr) + acc_t'(terms.p_uh) + bias_al;
    // Arithmetic shift, rounds toward minus infinity
    scaled  = acc >>> gate_num_pkg::frac_w;

    // Clamp
    if (scaled > word_max) begin
      sat = word_max[gate_num_pkg::word_w-1:0];
    end else if (scaled < word_min) begin
      sat = word_min[gate_num_pkg::word_w-1:0];
    end else begin
      sat = scaled[gate_num_pkg::word_w-1:0];
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Output register
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      pre_valid <= 1'b0;
      pre_last  <= 1'b0;
      pre       <= '0;
    end else begin
      pre_valid <= terms.valid;
      pre_last  <= terms.valid & terms.last;
      if (terms.valid) begin
        pre <= sat;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/gate_product_stage.sv
// Output gate, stage 1
// Registered elementwise products w*x, k*r and u*h at full width
`timescale 1ns/100ps
`default_nettype none

module gate_product_stage (
  input  logic                CLK,
  input  logic                RST,

  // Element strobe and end of vector
  input  logic                in_valid,
  input  logic                in_last,

  // Weight/input pairs and bias
  input  gate_num_pkg::word_t w,
  input  gate_num_pkg::word_t x,
  input  gate_num_pkg::word_t k,
  input  gate_num_pkg::word_t r,
  input  gate_num_pkg::word_t u,
  input  gate_num_pkg::word_t h,
  input  gate_num_pkg::word_t b,

  // To the sum stage
  gate_term_if.src            terms
);

  ///////////////////////////////////////////////////////////////////////
  // Flags
  ///////////////////////////////////////////////////////////////////////

  // One register of delay, last only seen together with valid
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      terms.valid <= 1'b0;
      terms.last  <= 1'b0;
    end else begin
      terms.valid <= in_valid;
      terms.last  <= in_valid & in_last;
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Products
  ///////////////////////////////////////////////////////////////////////

  // Signed 16x16 into 32, no rounding here
  // Held between strobes
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      terms.p_wx <= '0;
      terms.p_kr <= '0;
      terms.p_uh <= '0;
      terms.bias <= '0;
    end else if (in_valid) begin
      terms.p_wx <= w * x;
      terms.p_kr <= k * r;
      terms.p_uh <= u * h;
      // Bias passes through, aligned later
      terms.bias <= b;
    end
  end

endmodule

`default_nettype wire

//--- common/gate_term_if.sv
// Product-to-sum link
// Three registered products, the bias and the element flags
`timescale 1ns/100ps
`default_nettype none

interface gate_term_if;

  // Element strobe, one cycle per element
  logic                  valid;
  // End of vector, qualified by valid
  logic                  last;

  // Weighted products in Q8.22
  gate_num_pkg::prod_t   p_wx;
  gate_num_pkg::prod_t   p_kr;
  gate_num_pkg::prod_t   p_uh;

  // Bias still in Q4.11
  gate_num_pkg::word_t   bias;

  // Product stage side
  modport src (output valid, last, p_wx, p_kr, p_uh, bias);

  // Sum stage side
  modport dst (input valid, last, p_wx, p_kr, p_uh, bias);

endinterface

`default_nettype wire

//--- common/gate_lut_pkg.sv
// Logistic lookup table
// Base points of the piecewise-linear sigmoid on [0, 8]
`default_nettype none

package gate_lut_pkg;

  ///////////////////////////////////////////////////////////////////////
  // Segments
  ///////////////////////////////////////////////////////////////////////

  // Unit-wide segments on the positive half
  localparam int seg_n = 8;

  // sigmoid(i) * 2048, rounded to nearest, i = 0 .. seg_n
  // Flat at 2047 from the last point on
  localparam logic [11:0] sig_base [0:seg_n] = '{
    12'd1024,
    12'd1497,
    12'd1804,
    12'd1951,
    12'd2011,
    12'd2034,
    12'd2043,
    12'd2046,
    12'd2047
  };

endpackage

`default_nettype wire

//--- common/gate_num_pkg.sv
// Output gate number format
// Q4.11 data words, full-width Q8.22 products and the
// two-way view of the pre-activation word
`default_nettype none

package gate_num_pkg;

  ///////////////////////////////////////////////////////////////////////
  // Widths
  ///////////////////////////////////////////////////////////////////////

  // Every data word on the stream
  localparam int word_w = 16;
  // Fractional bits of a word
  localparam int frac_w = 11;
  // Integer bits, sign excluded
  localparam int int_w  = 4;
  // Full product of two words
  localparam int prod_w = 32;

  ///////////////////////////////////////////////////////////////////////
  // Types
  ///////////////////////////////////////////////////////////////////////

  // Signed Q4.11 value
  typedef logic signed [word_w-1:0] word_t;

  // Signed Q8.22 product, never rounded
  typedef logic signed [prod_w-1:0] prod_t;

  // Bit fields of a Q4.11 word
  typedef struct packed {
    logic              sign;
    logic [int_w-1:0]  int_part;
    logic [frac_w-1:0] frac;
  } word_fields_t;

  // Pre-activation word
  // Value view for sign test and negation, field view for segment lookup
  typedef union packed {
    word_t        value;
    word_fields_t fields;
  } pre_word_u;

  ///////////////////////////////////////////////////////////////////////
  // Constants
  ///////////////////////////////////////////////////////////////////////

  // 1.0 in Q4.11
  localparam word_t one_q = 16'sd2048;

endpackage

`default_nettype wire
